//--- hdl/vmul_pkg.sv
/*
 * Vector multiply unit package
 * Datapath widths, queue depths, multiplier latency and the
 * element width and operation encodings shared by the lane unit
 */
`default_nettype none

package vmul_pkg;

  // Datapath and vector register file geometry
  localparam int unsigned ElenBits  = 64;
  localparam int unsigned NrVInsn   = 8;
  localparam int unsigned VRegWords = 16;

  // Queue depths and pipeline stages
  localparam int unsigned InsnQueueDepth   = 4;
  localparam int unsigned ResultQueueDepth = 2;
  localparam int unsigned MulLatency       = 2;

  typedef logic [ElenBits-1:0]   elen_t;
  typedef logic [ElenBits/8-1:0] strb_t;
  typedef logic [2:0]            vid_t;
  typedef logic [4:0]            vreg_t;
  // Element count, at most 128
  typedef logic [7:0]            vlen_t;
  typedef logic [8:0]            vaddr_t;

  typedef enum logic [1:0] {
    ew8  = 2'd0,
    ew16 = 2'd1,
    ew32 = 2'd2,
    ew64 = 2'd3
  } vew_e;

  typedef enum logic [1:0] {
    op_mul   = 2'd0,
    op_mulh  = 2'd1,
    op_mulhu = 2'd2,
    op_macc  = 2'd3
  } mul_op_e;

endpackage

`default_nettype wire

//--- hdl/vmul_ctrl.sv
/*
 * Vector multiply unit control
 * In-order instruction queue with accept, issue, processing and commit
 * phases, per-phase element counters, operand handshakes, result
 * address and byte-enable generation, and per-ID done pulses
 */
`default_nettype none

module vmul_ctrl import vmul_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               insn_valid_i,
  input  mul_op_e            insn_op_i,
  input  vew_e               insn_vew_i,
  input  vlen_t              insn_vl_i,
  input  vreg_t              insn_vd_i,
  input  vid_t               insn_id_i,
  input  logic               insn_use_scalar_i,
  input  elen_t              insn_scalar_i,
  output logic               insn_ready_o,
  input  logic               operand_vs1_valid_i,
  input  logic               operand_vs2_valid_i,
  input  logic               operand_vd_valid_i,
  output logic               operand_vs1_ready_o,
  output logic               operand_vs2_ready_o,
  output logic               operand_vd_ready_o,
  output logic               issue_valid_o,
  output mul_op_e            issue_op_o,
  output vew_e               issue_vew_o,
  output logic               issue_use_scalar_o,
  output elen_t              issue_scalar_o,
  input  logic               mul_stall_i,
  input  logic               mul_valid_i,
  input  logic               rq_full_i,
  input  logic               rq_pop_i,
  output logic               rq_push_o,
  output vid_t               rq_id_o,
  output vaddr_t             rq_addr_o,
  output strb_t              rq_be_o,
  output logic [NrVInsn-1:0] vinsn_done_o
);

  typedef logic [$clog2(InsnQueueDepth)-1:0] pnt_t;
  typedef logic [$clog2(InsnQueueDepth):0]   cnt_t;

  // Instruction storage
  mul_op_e op_q         [InsnQueueDepth];
  vew_e    vew_q        [InsnQueueDepth];
  vlen_t   vl_q         [InsnQueueDepth];
  vreg_t   vd_q         [InsnQueueDepth];
  vid_t    id_q         [InsnQueueDepth];
  logic    use_scalar_q [InsnQueueDepth];
  elen_t   scalar_q     [InsnQueueDepth];

  pnt_t accept_pnt_d, accept_pnt_q;
  pnt_t issue_pnt_d, issue_pnt_q;
  pnt_t proc_pnt_d, proc_pnt_q;
  pnt_t commit_pnt_d, commit_pnt_q;
  cnt_t issue_cnt_d, issue_cnt_q;
  cnt_t proc_cnt_d, proc_cnt_q;
  cnt_t commit_cnt_d, commit_cnt_q;

  // Remaining elements of the instruction in each phase
  vlen_t issue_rem_d, issue_rem_q;
  vlen_t proc_rem_d, proc_rem_q;
  vlen_t commit_rem_d, commit_rem_q;

  logic [NrVInsn-1:0] done_d, done_q;
  logic insn_accept;
  logic need_vs1;
  logic need_vd;
  logic operands_ok;

  function automatic vlen_t min_elems(vlen_t rem, vew_e ew);
    vlen_t epw;
    epw = vlen_t'(8) >> ew;
    return (rem < epw) ? rem : epw;
  endfunction

  // One byte enable per byte of the active elements
  function automatic strb_t be_mask(vlen_t cnt, vew_e ew);
    vlen_t      nbytes;
    logic [8:0] ones;
    nbytes = cnt << ew;
    ones   = (9'd1 << nbytes) - 9'd1;
    return ones[7:0];
  endfunction

  assign insn_ready_o = (commit_cnt_q != cnt_t'(InsnQueueDepth));
  assign insn_accept  = insn_valid_i && insn_ready_o;

  // Issue side, vs1 is replaced by the scalar and vd is read for macc only
  assign need_vs1    = !use_scalar_q[issue_pnt_q];
  assign need_vd     = (op_q[issue_pnt_q] == op_macc);
  assign operands_ok = operand_vs2_valid_i && (operand_vs1_valid_i || !need_vs1) &&
                       (operand_vd_valid_i || !need_vd);

  assign issue_valid_o       = (issue_cnt_q != '0) && operands_ok && !mul_stall_i;
  assign operand_vs2_ready_o = issue_valid_o;
  assign operand_vs1_ready_o = issue_valid_o && need_vs1;
  assign operand_vd_ready_o  = issue_valid_o && need_vd;
  assign issue_op_o          = op_q[issue_pnt_q];
  assign issue_vew_o         = vew_q[issue_pnt_q];
  assign issue_use_scalar_o  = use_scalar_q[issue_pnt_q];
  assign issue_scalar_o      = scalar_q[issue_pnt_q];

  // Word index is the processed element count divided by elements per word
  assign rq_push_o = mul_valid_i && !rq_full_i;
  assign rq_id_o   = id_q[proc_pnt_q];
  assign rq_addr_o = vaddr_t'(vd_q[proc_pnt_q]) * vaddr_t'(VRegWords) +
                     vaddr_t'((vl_q[proc_pnt_q] - proc_rem_q) >> (2'd3 - 2'(vew_q[proc_pnt_q])));
  assign rq_be_o   = be_mask(min_elems(proc_rem_q, vew_q[proc_pnt_q]), vew_q[proc_pnt_q]);

  assign vinsn_done_o = done_q;

  always_comb begin
    accept_pnt_d = accept_pnt_q;
    issue_pnt_d  = issue_pnt_q;
    proc_pnt_d   = proc_pnt_q;
    commit_pnt_d = commit_pnt_q;
    issue_cnt_d  = issue_cnt_q;
    proc_cnt_d   = proc_cnt_q;
    commit_cnt_d = commit_cnt_q;
    issue_rem_d  = issue_rem_q;
    proc_rem_d   = proc_rem_q;
    commit_rem_d = commit_rem_q;
    done_d       = '0;

    if (issue_valid_o) begin
      issue_rem_d = issue_rem_q - min_elems(issue_rem_q, vew_q[issue_pnt_q]);
      if (issue_rem_d == '0) begin
        issue_cnt_d = issue_cnt_q - cnt_t'(1);
        issue_pnt_d = issue_pnt_q + pnt_t'(1);
        if (issue_cnt_d != '0) begin
          issue_rem_d = vl_q[issue_pnt_d];
        end
      end
    end

    if (rq_push_o) begin
      proc_rem_d = proc_rem_q - min_elems(proc_rem_q, vew_q[proc_pnt_q]);
      if (proc_rem_d == '0) begin
        proc_cnt_d = proc_cnt_q - cnt_t'(1);
        proc_pnt_d = proc_pnt_q + pnt_t'(1);
        if (proc_cnt_d != '0) begin
          proc_rem_d = vl_q[proc_pnt_d];
        end
      end
    end

    // Each granted word retires its elements, the last one ends the instruction
    if (rq_pop_i) begin
      commit_rem_d = commit_rem_q - min_elems(commit_rem_q, vew_q[commit_pnt_q]);
      if (commit_rem_d == '0) begin
        done_d[id_q[commit_pnt_q]] = 1'b1;
        commit_cnt_d = commit_cnt_q - cnt_t'(1);
        commit_pnt_d = commit_pnt_q + pnt_t'(1);
        if (commit_cnt_d != '0) begin
          commit_rem_d = vl_q[commit_pnt_d];
        end
      end
    end

    // A new instruction loads the counters of every phase it is first in
    if (insn_accept) begin
      if (issue_cnt_d == '0) begin
        issue_rem_d = insn_vl_i;
      end
      if (proc_cnt_d == '0) begin
        proc_rem_d = insn_vl_i;
      end
      if (commit_cnt_d == '0) begin
        commit_rem_d = insn_vl_i;
      end
      accept_pnt_d = accept_pnt_q + pnt_t'(1);
      issue_cnt_d  = issue_cnt_d + cnt_t'(1);
      proc_cnt_d   = proc_cnt_d + cnt_t'(1);
      commit_cnt_d = commit_cnt_d + cnt_t'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      proc_pnt_q   <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      proc_cnt_q   <= '0;
      commit_cnt_q <= '0;
      issue_rem_q  <= '0;
      proc_rem_q   <= '0;
      commit_rem_q <= '0;
      done_q       <= '0;
    end else begin
      accept_pnt_q <= accept_pnt_d;
      issue_pnt_q  <= issue_pnt_d;
      proc_pnt_q   <= proc_pnt_d;
      commit_pnt_q <= commit_pnt_d;
      issue_cnt_q  <= issue_cnt_d;
      proc_cnt_q   <= proc_cnt_d;
      commit_cnt_q <= commit_cnt_d;
      issue_rem_q  <= issue_rem_d;
      proc_rem_q   <= proc_rem_d;
      commit_rem_q <= commit_rem_d;
      done_q       <= done_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (insn_accept) begin
      op_q[accept_pnt_q]         <= insn_op_i;
      vew_q[accept_pnt_q]        <= insn_vew_i;
      vl_q[accept_pnt_q]         <= insn_vl_i;
      vd_q[accept_pnt_q]         <= insn_vd_i;
      id_q[accept_pnt_q]         <= insn_id_i;
      use_scalar_q[accept_pnt_q] <= insn_use_scalar_i;
      scalar_q[accept_pnt_q]     <= insn_scalar_i;
    end
  end

endmodule

`default_nettype wire

//--- hdl/vmul_simd_mul.sv
/*
 * SIMD integer multiplier
 * Replicates a scalar operand across the word, multiplies 8, 16, 32
 * or 64-bit lanes and returns the low half, a high half or vd plus
 * the low half through a pipeline that freezes on output back-pressure
 */
`default_nettype none

module vmul_simd_mul import vmul_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    issue_valid_i,
  input  mul_op_e issue_op_i,
  input  vew_e    issue_vew_i,
  input  logic    issue_use_scalar_i,
  input  elen_t   issue_scalar_i,
  input  elen_t   operand_vs1_i,
  input  elen_t   operand_vs2_i,
  input  elen_t   operand_vd_i,
  input  logic    out_ready_i,
  output logic    stall_o,
  output logic    valid_o,
  output elen_t   result_o
);

  elen_t       scalar_rep;
  elen_t       op_a;
  elen_t [3:0] ew_result;
  logic        valid_q [MulLatency];
  elen_t       data_q  [MulLatency];

  always_comb begin
    unique case (issue_vew_i)
      ew8:     scalar_rep = {8{issue_scalar_i[7:0]}};
      ew16:    scalar_rep = {4{issue_scalar_i[15:0]}};
      ew32:    scalar_rep = {2{issue_scalar_i[31:0]}};
      default: scalar_rep = issue_scalar_i;
    endcase
  end

  assign op_a = issue_use_scalar_i ? scalar_rep : operand_vs1_i;

  // One lane array per element width, lane width is 8 << w
  for (genvar w = 0; w < 4; w++) begin : gen_ew
    for (genvar l = 0; l < (8 >> w); l++) begin : gen_lane
      logic        [(16<<w)-1:0] prod_u;
      logic signed [(16<<w)-1:0] prod_s;

      assign prod_u = op_a[l*(8<<w) +: (8<<w)] * operand_vs2_i[l*(8<<w) +: (8<<w)];
      assign prod_s = $signed(op_a[l*(8<<w) +: (8<<w)]) *
                      $signed(operand_vs2_i[l*(8<<w) +: (8<<w)]);

      assign ew_result[w][l*(8<<w) +: (8<<w)] =
        (issue_op_i == op_mulh)  ? prod_s[(16<<w)-1 -: (8<<w)] :
        (issue_op_i == op_mulhu) ? prod_u[(16<<w)-1 -: (8<<w)] :
        (issue_op_i == op_macc)  ? operand_vd_i[l*(8<<w) +: (8<<w)] + prod_u[(8<<w)-1:0] :
                                   prod_u[(8<<w)-1:0];
    end
  end

  // Whole pipeline holds while the last stage waits
  assign stall_o  = valid_q[MulLatency-1] && !out_ready_i;
  assign valid_o  = valid_q[MulLatency-1];
  assign result_o = data_q[MulLatency-1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < MulLatency; s++) begin
        valid_q[s] <= 1'b0;
      end
    end else if (!stall_o) begin
      valid_q[0] <= issue_valid_i;
      for (int s = 1; s < MulLatency; s++) begin
        valid_q[s] <= valid_q[s-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_o) begin
      data_q[0] <= ew_result[issue_vew_i];
      for (int s = 1; s < MulLatency; s++) begin
        data_q[s] <= data_q[s-1];
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/vmul_result_queue.sv
/*
 * Result queue
 * Small FIFO of finished words whose head drives the vector register
 * file write request until it is granted
 */
`default_nettype none

module vmul_result_queue import vmul_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   push_i,
  input  vid_t   push_id_i,
  input  vaddr_t push_addr_i,
  input  elen_t  push_wdata_i,
  input  strb_t  push_be_i,
  input  logic   result_gnt_i,
  output logic   full_o,
  output logic   pop_o,
  output logic   result_req_o,
  output vid_t   result_id_o,
  output vaddr_t result_addr_o,
  output elen_t  result_wdata_o,
  output strb_t  result_be_o
);

  typedef logic [$clog2(ResultQueueDepth)-1:0] pnt_t;
  typedef logic [$clog2(ResultQueueDepth):0]   cnt_t;

  vid_t   id_q    [ResultQueueDepth];
  vaddr_t addr_q  [ResultQueueDepth];
  elen_t  wdata_q [ResultQueueDepth];
  strb_t  be_q    [ResultQueueDepth];
  pnt_t   wr_pnt_q;
  pnt_t   rd_pnt_q;
  cnt_t   cnt_q;

  assign full_o         = (cnt_q == cnt_t'(ResultQueueDepth));
  assign result_req_o   = (cnt_q != '0);
  assign pop_o          = result_req_o && result_gnt_i;
  assign result_id_o    = id_q[rd_pnt_q];
  assign result_addr_o  = addr_q[rd_pnt_q];
  assign result_wdata_o = wdata_q[rd_pnt_q];
  assign result_be_o    = be_q[rd_pnt_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_pnt_q <= (wr_pnt_q == pnt_t'(ResultQueueDepth-1)) ? '0 : wr_pnt_q + pnt_t'(1);
      end
      if (pop_o) begin
        rd_pnt_q <= (rd_pnt_q == pnt_t'(ResultQueueDepth-1)) ? '0 : rd_pnt_q + pnt_t'(1);
      end
      cnt_q <= cnt_q + cnt_t'(push_i) - cnt_t'(pop_o);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      id_q[wr_pnt_q]    <= push_id_i;
      addr_q[wr_pnt_q]  <= push_addr_i;
      wdata_q[wr_pnt_q] <= push_wdata_i;
      be_q[wr_pnt_q]    <= push_be_i;
    end
  end

endmodule

`default_nettype wire

//--- hdl/vmul_top.sv
/*
 * Vector integer multiply unit, one lane
 * Control, SIMD multiplier pipeline and result queue
 */
`default_nettype none

module vmul_top import vmul_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               insn_valid_i,
  input  mul_op_e            insn_op_i,
  input  vew_e               insn_vew_i,
  input  vlen_t              insn_vl_i,
  input  vreg_t              insn_vd_i,
  input  vid_t               insn_id_i,
  input  logic               insn_use_scalar_i,
  input  elen_t              insn_scalar_i,
  output logic               insn_ready_o,
  input  elen_t              operand_vs1_i,
  input  logic               operand_vs1_valid_i,
  output logic               operand_vs1_ready_o,
  input  elen_t              operand_vs2_i,
  input  logic               operand_vs2_valid_i,
  output logic               operand_vs2_ready_o,
  input  elen_t              operand_vd_i,
  input  logic               operand_vd_valid_i,
  output logic               operand_vd_ready_o,
  output logic               result_req_o,
  output vid_t               result_id_o,
  output vaddr_t             result_addr_o,
  output elen_t              result_wdata_o,
  output strb_t              result_be_o,
  input  logic               result_gnt_i,
  output logic [NrVInsn-1:0] vinsn_done_o
);

  logic    issue_valid;
  mul_op_e issue_op;
  vew_e    issue_vew;
  logic    issue_use_scalar;
  elen_t   issue_scalar;
  logic    mul_stall;
  logic    mul_valid;
  elen_t   mul_result;
  logic    rq_push;
  vid_t    rq_id;
  vaddr_t  rq_addr;
  strb_t   rq_be;
  logic    rq_full;
  logic    rq_pop;

  vmul_ctrl i_ctrl (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .insn_valid_i        (insn_valid_i),
    .insn_op_i           (insn_op_i),
    .insn_vew_i          (insn_vew_i),
    .insn_vl_i           (insn_vl_i),
    .insn_vd_i           (insn_vd_i),
    .insn_id_i           (insn_id_i),
    .insn_use_scalar_i   (insn_use_scalar_i),
    .insn_scalar_i       (insn_scalar_i),
    .insn_ready_o        (insn_ready_o),
    .operand_vs1_valid_i (operand_vs1_valid_i),
    .operand_vs2_valid_i (operand_vs2_valid_i),
    .operand_vd_valid_i  (operand_vd_valid_i),
    .operand_vs1_ready_o (operand_vs1_ready_o),
    .operand_vs2_ready_o (operand_vs2_ready_o),
    .operand_vd_ready_o  (operand_vd_ready_o),
    .issue_valid_o       (issue_valid),
    .issue_op_o          (issue_op),
    .issue_vew_o         (issue_vew),
    .issue_use_scalar_o  (issue_use_scalar),
    .issue_scalar_o      (issue_scalar),
    .mul_stall_i         (mul_stall),
    .mul_valid_i         (mul_valid),
    .rq_full_i           (rq_full),
    .rq_pop_i            (rq_pop),
    .rq_push_o           (rq_push),
    .rq_id_o             (rq_id),
    .rq_addr_o           (rq_addr),
    .rq_be_o             (rq_be),
    .vinsn_done_o        (vinsn_done_o)
  );

  // Output stage waits whenever the result queue has no room
  vmul_simd_mul i_simd_mul (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .issue_valid_i      (issue_valid),
    .issue_op_i         (issue_op),
    .issue_vew_i        (issue_vew),
    .issue_use_scalar_i (issue_use_scalar),
    .issue_scalar_i     (issue_scalar),
    .operand_vs1_i      (operand_vs1_i),
    .operand_vs2_i      (operand_vs2_i),
    .operand_vd_i       (operand_vd_i),
    .out_ready_i        (!rq_full),
    .stall_o            (mul_stall),
    .valid_o            (mul_valid),
    .result_o           (mul_result)
  );

  vmul_result_queue i_result_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .push_i         (rq_push),
    .push_id_i      (rq_id),
    .push_addr_i    (rq_addr),
    .push_wdata_i   (mul_result),
    .push_be_i      (rq_be),
    .result_gnt_i   (result_gnt_i),
    .full_o         (rq_full),
    .pop_o          (rq_pop),
    .result_req_o   (result_req_o),
    .result_id_o    (result_id_o),
    .result_addr_o  (result_addr_o),
    .result_wdata_o (result_wdata_o),
    .result_be_o    (result_be_o)
  );

endmodule

`default_nettype wire

//--- verif/vmul_assertions.sv
/*
 * Protocol checks for the vector multiply unit
 * Register file request stability, operand handshakes and done pulses
 */
`default_nettype none

module vmul_assertions import vmul_pkg::*; (
  input logic               clk_i,
  input logic               rst_ni,
  input logic               result_req_o,
  input logic               result_gnt_i,
  input vid_t               result_id_o,
  input vaddr_t             result_addr_o,
  input elen_t              result_wdata_o,
  input strb_t              result_be_o,
  input logic               operand_vs1_valid_i,
  input logic               operand_vs1_ready_o,
  input logic               operand_vs2_valid_i,
  input logic               operand_vs2_ready_o,
  input logic               operand_vd_valid_i,
  input logic               operand_vd_ready_o,
  input logic [NrVInsn-1:0] vinsn_done_o
);

  // A pending request keeps its payload until it is granted
  req_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_req_o && !result_gnt_i |=> result_req_o && $stable(result_wdata_o) &&
      $stable(result_addr_o) && $stable(result_be_o) && $stable(result_id_o))
    else $error("result request dropped or changed before its grant");

  vs1_ready_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    operand_vs1_ready_o |-> operand_vs1_valid_i)
    else $error("vs1 ready pulsed without a valid word");

  vs2_ready_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    operand_vs2_ready_o |-> operand_vs2_valid_i)
    else $error("vs2 ready pulsed without a valid word");

  vd_ready_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    operand_vd_ready_o |-> operand_vd_valid_i)
    else $error("vd ready pulsed without a valid word");

  done_onehot_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(vinsn_done_o))
    else $error("more than one done bit set");

endmodule

bind vmul_top vmul_assertions i_assertions (
  .clk_i               (clk_i),
  .rst_ni              (rst_ni),
  .result_req_o        (result_req_o),
  .result_gnt_i        (result_gnt_i),
  .result_id_o         (result_id_o),
  .result_addr_o       (result_addr_o),
  .result_wdata_o      (result_wdata_o),
  .result_be_o         (result_be_o),
  .operand_vs1_valid_i (operand_vs1_valid_i),
  .operand_vs1_ready_o (operand_vs1_ready_o),
  .operand_vs2_valid_i (operand_vs2_valid_i),
  .operand_vs2_ready_o (operand_vs2_ready_o),
  .operand_vd_valid_i  (operand_vd_valid_i),
  .operand_vd_ready_o  (operand_vd_ready_o),
  .vinsn_done_o        (vinsn_done_o)
);

`default_nettype wire

//--- verif/tb_vmul.sv
/*
 * Testbench for the vector integer multiply unit
 * Directed tests with operand queue models, a lane-level reference
 * model of mul, mulh, mulhu and macc, and a result and done monitor
 */
`default_nettype none

module tb_vmul import vmul_pkg::*; ();

  localparam int Timeout = 200;

  logic               clk_i;
  logic               rst_ni;
  logic               insn_valid_i;
  mul_op_e            insn_op_i;
  vew_e               insn_vew_i;
  vlen_t              insn_vl_i;
  vreg_t              insn_vd_i;
  vid_t               insn_id_i;
  logic               insn_use_scalar_i;
  elen_t              insn_scalar_i;
  logic               insn_ready_o;
  elen_t              operand_vs1_i;
  logic               operand_vs1_valid_i;
  logic               operand_vs1_ready_o;
  elen_t              operand_vs2_i;
  logic               operand_vs2_valid_i;
  logic               operand_vs2_ready_o;
  elen_t              operand_vd_i;
  logic               operand_vd_valid_i;
  logic               operand_vd_ready_o;
  logic               result_req_o;
  vid_t               result_id_o;
  vaddr_t             result_addr_o;
  elen_t              result_wdata_o;
  strb_t              result_be_o;
  logic               result_gnt_i;
  logic [NrVInsn-1:0] vinsn_done_o;

  integer seed = 87149;
  int     cycle = 0;

  // Operand queue models
  elen_t vs1_q[$];
  elen_t vs2_q[$];
  elen_t vd_q[$];

  // Expected and observed register file writes
  elen_t  exp_data[$];
  vaddr_t exp_addr[$];
  strb_t  exp_be[$];
  vid_t   exp_id[$];
  elen_t  obs_data[$];
  vaddr_t obs_addr[$];
  strb_t  obs_be[$];
  vid_t   obs_id[$];

  // Done pulses and the cycle of each ID's latest grant
  vid_t done_ids[$];
  int   done_cycle[$];
  int   last_gnt[NrVInsn];

  vmul_top dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle <= cycle + 1;
  end

  task automatic end_with_failure();
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic report_error(string msg);
    $display("ERROR at time %0t: %s", $time, msg);
    end_with_failure();
  endtask

  task automatic check_word(string name, elen_t got, elen_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at time %0t: %s got %h expected %h", $time, name, got, exp);
      end_with_failure();
    end
  endtask

  task automatic check_addr(string name, vaddr_t got, vaddr_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at time %0t: %s got %h expected %h", $time, name, got, exp);
      end_with_failure();
    end
  endtask

  task automatic check_be(string name, strb_t got, strb_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at time %0t: %s got %h expected %h", $time, name, got, exp);
      end_with_failure();
    end
  endtask

  task automatic check_id(string name, vid_t got, vid_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at time %0t: %s got %h expected %h", $time, name, got, exp);
      end_with_failure();
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED at time %0t: %s got %b expected %b", $time, name, got, exp);
      end_with_failure();
    end
  endtask

  function automatic elen_t rand_word();
    return {$random(seed), $random(seed)};
  endfunction

  // Copies the low element of the scalar into every element slot
  function automatic elen_t replicate(elen_t s, vew_e ew);
    elen_t r;
    int    ebits;
    ebits = 8 << ew;
    for (int i = 0; i < 64; i++) begin
      r[i] = s[i % ebits];
    end
    return r;
  endfunction

  // Reference lane model on 128-bit intermediates
  function automatic elen_t model_word(mul_op_e op, vew_e ew, elen_t a, elen_t b, elen_t c);
    elen_t        res;
    logic [127:0] mask;
    logic [127:0] ua, ub, sa, sb, lane;
    int           ebits;
    ebits = 8 << ew;
    mask  = (128'd1 << ebits) - 128'd1;
    res   = '0;
    for (int e = 0; e < 64 / ebits; e++) begin
      ua = (128'(a) >> (e * ebits)) & mask;
      ub = (128'(b) >> (e * ebits)) & mask;
      sa = ua[ebits-1] ? (ua | ~mask) : ua;
      sb = ub[ebits-1] ? (ub | ~mask) : ub;
      case (op)
        op_mulh:  lane = (sa * sb) >> ebits;
        op_mulhu: lane = (ua * ub) >> ebits;
        op_macc:  lane = (ua * ub) + (128'(c) >> (e * ebits));
        default:  lane = ua * ub;
      endcase
      res = res | elen_t'((lane & mask) << (e * ebits));
    end
    return res;
  endfunction

  // Byte j belongs to element j >> ew
  function automatic strb_t model_be(int cnt, vew_e ew);
    strb_t be;
    for (int j = 0; j < 8; j++) begin
      be[j] = ((j >> ew) < cnt);
    end
    return be;
  endfunction

  // Operand queues pop on the ready pulse seen in the previous cycle
  initial begin : operand_driver
    logic pop_vs1;
    logic pop_vs2;
    logic pop_vd;
    forever begin
      @(negedge clk_i);
      pop_vs1 = operand_vs1_ready_o;
      pop_vs2 = operand_vs2_ready_o;
      pop_vd  = operand_vd_ready_o;
      @(posedge clk_i);
      #1;
      if (pop_vs1 && vs1_q.size() != 0) void'(vs1_q.pop_front());
      if (pop_vs2 && vs2_q.size() != 0) void'(vs2_q.pop_front());
      if (pop_vd && vd_q.size() != 0) void'(vd_q.pop_front());
      operand_vs1_valid_i = (vs1_q.size() != 0);
      operand_vs2_valid_i = (vs2_q.size() != 0);
      operand_vd_valid_i  = (vd_q.size() != 0);
      operand_vs1_i = operand_vs1_valid_i ? vs1_q[0] : '0;
      operand_vs2_i = operand_vs2_valid_i ? vs2_q[0] : '0;
      operand_vd_i  = operand_vd_valid_i ? vd_q[0] : '0;
    end
  end

  always @(negedge clk_i) begin
    if (rst_ni && result_req_o && result_gnt_i) begin
      obs_data.push_back(result_wdata_o);
      obs_addr.push_back(result_addr_o);
      obs_be.push_back(result_be_o);
      obs_id.push_back(result_id_o);
      last_gnt[result_id_o] = cycle;
    end
    for (int i = 0; i < NrVInsn; i++) begin
      if (rst_ni && vinsn_done_o[i]) begin
        done_ids.push_back(vid_t'(i));
        done_cycle.push_back(cycle);
      end
    end
  end

  // Holds the instruction until it is accepted
  task automatic send_insn(mul_op_e op, vew_e ew, int vl, vreg_t vd, vid_t id,
                           logic use_scalar, elen_t scalar);
    int   waited;
    logic taken;
    insn_valid_i      = 1'b1;
    insn_op_i         = op;
    insn_vew_i        = ew;
    insn_vl_i         = vlen_t'(vl);
    insn_vd_i         = vd;
    insn_id_i         = id;
    insn_use_scalar_i = use_scalar;
    insn_scalar_i     = scalar;
    waited = 0;
    taken  = 1'b0;
    while (!taken) begin
      @(negedge clk_i);
      taken = insn_ready_o;
      @(posedge clk_i);
      #1;
      waited++;
      if (!taken && waited >= Timeout) begin
        report_error("instruction was not accepted within the timeout");
      end
    end
    insn_valid_i = 1'b0;
  endtask

  // Loads operands, records the expected writes and sends the instruction
  task automatic queue_insn(mul_op_e op, vew_e ew, int vl, vreg_t vd, vid_t id,
                            logic use_scalar, elen_t scalar);
    int    epw;
    int    left;
    elen_t a, b, c;
    epw = 8 >> ew;
    for (int k = 0; k < (vl + epw - 1) / epw; k++) begin
      b = rand_word();
      a = use_scalar ? replicate(scalar, ew) : rand_word();
      c = rand_word();
      vs2_q.push_back(b);
      if (!use_scalar) vs1_q.push_back(a);
      if (op == op_macc) vd_q.push_back(c);
      left = vl - k * epw;
      exp_data.push_back(model_word(op, ew, a, b, c));
      exp_addr.push_back(vaddr_t'(int'(vd) * VRegWords + k));
      exp_be.push_back(model_be((left < epw) ? left : epw, ew));
      exp_id.push_back(id);
    end
    send_insn(op, ew, vl, vd, id, use_scalar, scalar);
  endtask

  task automatic wait_results();
    int waited;
    waited = 0;
    while (obs_data.size() < exp_data.size()) begin
      @(negedge clk_i);
      waited++;
      if (waited > Timeout) begin
        report_error("register file writes did not arrive within the timeout");
      end
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic compare_results();
    while (exp_data.size() != 0) begin
      check_id("result_id_o", obs_id.pop_front(), exp_id.pop_front());
      check_addr("result_addr_o", obs_addr.pop_front(), exp_addr.pop_front());
      check_be("result_be_o", obs_be.pop_front(), exp_be.pop_front());
      check_word("result_wdata_o", obs_data.pop_front(), exp_data.pop_front());
    end
    if (obs_data.size() != 0) begin
      report_error("the unit wrote more words than expected");
    end
  endtask

  task automatic test_reset_state();
    @(negedge clk_i);
    check_flag("insn_ready_o", insn_ready_o, 1'b1);
    check_flag("result_req_o", result_req_o, 1'b0);
    check_flag("operand_vs1_ready_o", operand_vs1_ready_o, 1'b0);
    check_flag("operand_vs2_ready_o", operand_vs2_ready_o, 1'b0);
    check_flag("operand_vd_ready_o", operand_vd_ready_o, 1'b0);
    check_flag("vinsn_done_o any", |vinsn_done_o, 1'b0);
    @(posedge clk_i);
    #1;
  endtask

  task automatic test_mul_widths();
    for (int w = 0; w < 4; w++) begin
      queue_insn(op_mul, vew_e'(w), 2 * (8 >> w), vreg_t'(w + 2), vid_t'(w), 1'b0, '0);
    end
    wait_results();
    compare_results();
  endtask

  task automatic test_mulh_scalar();
    queue_insn(op_mulh, ew16, 8, vreg_t'(9), vid_t'(4), 1'b1, rand_word());
    queue_insn(op_mulhu, ew16, 8, vreg_t'(10), vid_t'(5), 1'b1, rand_word());
    wait_results();
    compare_results();
  endtask

  task automatic test_macc_partial();
    queue_insn(op_macc, ew32, 3, vreg_t'(7), vid_t'(6), 1'b0, '0);
    wait_results();
    check_addr("first result_addr_o", obs_addr[0], vaddr_t'(7 * 16));
    check_be("last result_be_o", obs_be[1], 8'h0F);
    compare_results();
  endtask

  task automatic test_backpressure();
    result_gnt_i = 1'b0;
    for (int i = 0; i < 4; i++) begin
      queue_insn(op_mul, ew64, 2, vreg_t'(12 + i), vid_t'(i), 1'b0, '0);
    end
    // Four pending instructions fill the instruction queue
    @(negedge clk_i);
    check_flag("insn_ready_o", insn_ready_o, 1'b0);
    repeat (30) @(posedge clk_i);
    @(negedge clk_i);
    check_flag("result_req_o", result_req_o, 1'b1);
    // Only the result queue and the pipeline stages can hold issued words
    if (vs2_q.size() != 8 - ResultQueueDepth - MulLatency) begin
      report_error("issue did not stop while the result queue was full");
    end
    @(posedge clk_i);
    #1;
    result_gnt_i = 1'b1;
    wait_results();
    compare_results();
  endtask

  task automatic test_done_order();
    vid_t ids[3];
    int   waited;
    ids = '{vid_t'(5), vid_t'(2), vid_t'(7)};
    // Let pulses of earlier instructions go by
    repeat (3) @(posedge clk_i);
    #1;
    done_ids.delete();
    done_cycle.delete();
    queue_insn(op_mul, ew8, 12, vreg_t'(20), ids[0], 1'b0, '0);
    queue_insn(op_macc, ew16, 4, vreg_t'(21), ids[1], 1'b0, '0);
    queue_insn(op_mulhu, ew32, 5, vreg_t'(22), ids[2], 1'b1, rand_word());
    wait_results();
    waited = 0;
    while (done_ids.size() < 3) begin
      @(negedge clk_i);
      waited++;
      if (waited > Timeout) begin
        report_error("done pulses did not arrive within the timeout");
      end
    end
    @(posedge clk_i);
    #1;
    compare_results();
    for (int i = 0; i < 3; i++) begin
      check_id("vinsn_done_o order", done_ids[i], ids[i]);
      if (done_cycle[i] != last_gnt[ids[i]] + 1) begin
        report_error($sformatf("done of ID %0d is not one cycle after its last grant", ids[i]));
      end
    end
  endtask

  initial begin
    rst_ni              = 1'b0;
    insn_valid_i        = 1'b0;
    insn_op_i           = op_mul;
    insn_vew_i          = ew8;
    insn_vl_i           = '0;
    insn_vd_i           = '0;
    insn_id_i           = '0;
    insn_use_scalar_i   = 1'b0;
    insn_scalar_i       = '0;
    operand_vs1_i       = '0;
    operand_vs1_valid_i = 1'b0;
    operand_vs2_i       = '0;
    operand_vs2_valid_i = 1'b0;
    operand_vd_i        = '0;
    operand_vd_valid_i  = 1'b0;
    result_gnt_i        = 1'b1;
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    test_reset_state();
    test_mul_widths();
    test_mulh_scalar();
    test_macc_partial();
    test_backpressure();
    test_done_order();

    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
hdl/vmul_pkg.sv
hdl/vmul_ctrl.sv
hdl/vmul_simd_mul.sv
hdl/vmul_result_queue.sv
hdl/vmul_top.sv
verif/vmul_assertions.sv
verif/tb_vmul.sv

//--- run.sh
#!/bin/sh
# Builds the vector multiply unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir

verilator --binary --assert -Wno-fatal --top-module tb_vmul -f sources.f -o vsim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Build failed"
  exit 1
fi

./obj_dir/vsim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx ">>> PASS" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1
